//--- Makefile
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_decode_stage
SEED      ?= 2501
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -f $(FLIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) | tee /dev/stderr | grep "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
+incdir+design
design/decode_pkg.sv
design/instr_classifier.sv
design/operand_select.sv
design/hazard_unit.sv
design/issue_register.sv
design/decode_stage.sv
sim/tb_decode_stage.sv

//--- design/decode_defs.svh
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// Data and address width
`define XLEN 32

// Fetched instruction width
`define ILEN 32

// Register file index
`define REG_ADDR_W 5

// CSR address field of SYSTEM instructions
`define CSR_ADDR_W 12

`endif

//--- design/decode_pkg.sv
`default_nettype none

`include "decode_defs.svh"

package decode_pkg;

    // Major opcode, instruction bits 6:2
    typedef enum logic [4:0] {
        OPC_LOAD     = 5'b00000,
        OPC_MISC_MEM = 5'b00011,
        OPC_OP_IMM   = 5'b00100,
        OPC_AUIPC    = 5'b00101,
        OPC_STORE    = 5'b01000,
        OPC_OP       = 5'b01100,
        OPC_LUI      = 5'b01101,
        OPC_BRANCH   = 5'b11000,
        OPC_JALR     = 5'b11001,
        OPC_JAL      = 5'b11011,
        OPC_SYSTEM   = 5'b11100
    } opcode_e;

    // Operation handed to execute, immediate forms fold onto the register forms
    typedef enum logic [5:0] {
        NOP, LUI, AUIPC, JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        ECALL, EBREAK, MRET, SRET, WFI,
        CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI,
        INVALID
    } operation_e;

    typedef enum logic [2:0] {
        FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J
    } format_e;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`ILEN-1:0] instruction;
    } fetch_pkt_t;

    // Write port of a later stage, seen as a bypass source
    typedef struct packed {
        logic                   we;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } fwd_t;

    typedef struct packed {
        operation_e             op;
        format_e                format;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`XLEN-1:0]       imm;
        logic                   use_rs1;
        logic                   use_rs2;
        logic                   is_load;
        logic                   is_store;
        logic                   exc_illegal;
        logic                   exc_misaligned;
    } decoded_t;

    typedef struct packed {
        operation_e             op;
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;         // uimm of CSR*I
        logic [`XLEN-1:0]       rs1_data;
        logic [`XLEN-1:0]       rs2_data;
        logic [`XLEN-1:0]       second_operand;
        logic [`XLEN-1:0]       jump_target;
        logic [`CSR_ADDR_W-1:0] csr_address;
        logic                   exc_illegal;
        logic                   exc_misaligned;
    } issue_pkt_t;

endpackage

`default_nettype wire

//--- design/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_defs.svh"

module decode_stage (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      enable_i,
    input  logic                      flush_i,
    input  decode_pkg::fetch_pkt_t    fetch_i,
    output logic [`REG_ADDR_W-1:0]    rs1_addr_o,
    output logic [`REG_ADDR_W-1:0]    rs2_addr_o,
    input  logic [`XLEN-1:0]          rs1_rdata_i,
    input  logic [`XLEN-1:0]          rs2_rdata_i,
    input  decode_pkg::fwd_t          exec_fwd_i,
    input  decode_pkg::fwd_t          retire_fwd_i,
    output decode_pkg::issue_pkt_t    issue_o,
    output logic                      hazard_o,
    output logic                      killed_o
);
    import decode_pkg::*;

    decoded_t         decoded;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] second_operand;
    logic [`XLEN-1:0] jump_target;
    logic             bubble;

    // Register file reads straight from the fetched word
    assign rs1_addr_o = decoded.rs1;
    assign rs2_addr_o = decoded.rs2;

    instr_classifier classifier_i (
        .fetch_i   (fetch_i),
        .decoded_o (decoded)
    );

    operand_select operands_i (
        .decoded_i        (decoded),
        .pc_i             (fetch_i.pc),
        .rs1_rdata_i      (rs1_rdata_i),
        .rs2_rdata_i      (rs2_rdata_i),
        .exec_fwd_i       (exec_fwd_i),
        .retire_fwd_i     (retire_fwd_i),
        .rs1_data_o       (rs1_data),
        .rs2_data_o       (rs2_data),
        .second_operand_o (second_operand),
        .jump_target_o    (jump_target)
    );

    hazard_unit hazard_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .enable_i  (enable_i),
        .flush_i   (flush_i),
        .decoded_i (decoded),
        .hazard_o  (hazard_o),
        .bubble_o  (bubble),
        .killed_o  (killed_o)
    );

    issue_register issue_i (
        .clk              (clk),
        .reset_n          (reset_n),
        .enable_i         (enable_i),
        .bubble_i         (bubble),
        .pc_i             (fetch_i.pc),
        .decoded_i        (decoded),
        .rs1_data_i       (rs1_data),
        .rs2_data_i       (rs2_data),
        .second_operand_i (second_operand),
        .jump_target_i    (jump_target),
        .issue_o          (issue_o)
    );

endmodule

`default_nettype wire

//--- design/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_defs.svh"

module hazard_unit (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 enable_i,
    input  logic                 flush_i,
    input  decode_pkg::decoded_t decoded_i,
    output logic                 hazard_o,
    output logic                 bubble_o,
    output logic                 killed_o
);
    import decode_pkg::*;

    logic [`REG_ADDR_W-1:0] locked_reg;   // rd of the load just issued, x0 when free
    logic                   locked_mem;   // Store just issued
    logic hazard_rs1;
    logic hazard_rs2;
    logic hazard_mem;
    logic exception;

    ////////////////////////////////////////
    // Lock compare
    ////////////////////////////////////////

    assign hazard_rs1 = decoded_i.use_rs1 && decoded_i.rs1 != '0 && decoded_i.rs1 == locked_reg;
    assign hazard_rs2 = decoded_i.use_rs2 && decoded_i.rs2 != '0 && decoded_i.rs2 == locked_reg;
    assign hazard_mem = decoded_i.is_load && locked_mem;
    assign exception  = decoded_i.exc_illegal || decoded_i.exc_misaligned;

    // A trapping or flushed instruction never waits
    assign hazard_o = (hazard_rs1 || hazard_rs2 || hazard_mem) && !flush_i && !exception;
    assign bubble_o = hazard_o || flush_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            locked_reg <= '0;
            locked_mem <= 1'b0;
            killed_o   <= 1'b0;
        end else if (enable_i) begin
            killed_o <= flush_i;
            if (bubble_o) begin   // Nothing issued, nothing to wait on
                locked_reg <= '0;
                locked_mem <= 1'b0;
            end else begin
                locked_reg <= decoded_i.is_load ? decoded_i.rd : '0;
                locked_mem <= decoded_i.is_store;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/instr_classifier.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_defs.svh"

module instr_classifier (
    input  decode_pkg::fetch_pkt_t fetch_i,
    output decode_pkg::decoded_t   decoded_o
);
    import decode_pkg::*;

    logic [`ILEN-1:0] instr;
    opcode_e          opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;

    operation_e op_branch;
    operation_e op_load;
    operation_e op_store;
    operation_e op_alu;
    operation_e op_system;
    operation_e op;
    format_e    fmt;
    logic [`XLEN-1:0] imm;
    logic use_rs1;
    logic use_rs2;

    assign instr  = fetch_i.instruction;
    assign opcode = opcode_e'(instr[6:2]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    ////////////////////////////////////////
    // Operation tables
    ////////////////////////////////////////

    always_comb begin
        unique case (funct3)
            3'b000:  op_branch = BEQ;
            3'b001:  op_branch = BNE;
            3'b100:  op_branch = BLT;
            3'b101:  op_branch = BGE;
            3'b110:  op_branch = BLTU;
            3'b111:  op_branch = BGEU;
            default: op_branch = INVALID;
        endcase
    end

    always_comb begin
        unique case (funct3)
            3'b000:  op_load = LB;
            3'b001:  op_load = LH;
            3'b010:  op_load = LW;
            3'b100:  op_load = LBU;
            3'b101:  op_load = LHU;
            default: op_load = INVALID;
        endcase
        unique case (funct3)
            3'b000:  op_store = SB;
            3'b001:  op_store = SH;
            3'b010:  op_store = SW;
            default: op_store = INVALID;
        endcase
    end

    // OP and OP-IMM share one table, funct7 only matters for shifts and SUB
    always_comb begin
        unique case (funct3)
            3'b000: begin
                if (opcode == OPC_OP_IMM || funct7 == 7'b0000000)
                    op_alu = ADD;
                else if (opcode == OPC_OP && funct7 == 7'b0100000)
                    op_alu = SUB;
                else
                    op_alu = INVALID;
            end
            3'b001:  op_alu = (funct7 == 7'b0000000) ? SLL : INVALID;
            3'b101: begin
                if (funct7 == 7'b0000000)
                    op_alu = SRL;
                else if (funct7 == 7'b0100000)
                    op_alu = SRA;
                else
                    op_alu = INVALID;
            end
            3'b010:  op_alu = (opcode == OPC_OP_IMM || funct7 == '0) ? SLT : INVALID;
            3'b011:  op_alu = (opcode == OPC_OP_IMM || funct7 == '0) ? SLTU : INVALID;
            3'b100:  op_alu = (opcode == OPC_OP_IMM || funct7 == '0) ? XOR : INVALID;
            3'b110:  op_alu = (opcode == OPC_OP_IMM || funct7 == '0) ? OR : INVALID;
            default: op_alu = (opcode == OPC_OP_IMM || funct7 == '0) ? AND : INVALID;
        endcase
    end

    always_comb begin
        op_system = INVALID;
        unique case (funct3)
            3'b000: begin
                if (instr[19:7] == '0) begin   // Privileged ops carry no registers
                    unique case (instr[31:20])
                        12'h000: op_system = ECALL;
                        12'h001: op_system = EBREAK;
                        12'h302: op_system = MRET;
                        12'h102: op_system = SRET;
                        12'h105: op_system = WFI;
                        default: op_system = INVALID;
                    endcase
                end
            end
            3'b001:  op_system = CSRRW;
            3'b010:  op_system = CSRRS;
            3'b011:  op_system = CSRRC;
            3'b101:  op_system = CSRRWI;
            3'b110:  op_system = CSRRSI;
            3'b111:  op_system = CSRRCI;
            default: op_system = INVALID;
        endcase
    end

    always_comb begin
        unique case (opcode)
            OPC_LUI:              op = LUI;
            OPC_AUIPC:            op = AUIPC;
            OPC_JAL:              op = JAL;
            OPC_JALR:             op = (funct3 == 3'b000) ? JALR : INVALID;
            OPC_BRANCH:           op = op_branch;
            OPC_LOAD:             op = op_load;
            OPC_STORE:            op = op_store;
            OPC_OP_IMM, OPC_OP:   op = op_alu;
            OPC_MISC_MEM:         op = (funct3 == 3'b000) ? NOP : INVALID;   // FENCE
            OPC_SYSTEM:           op = op_system;
            default:              op = INVALID;
        endcase
    end

    ////////////////////////////////////////
    // Format and immediate
    ////////////////////////////////////////

    always_comb begin
        unique case (opcode)
            OPC_LOAD, OPC_OP_IMM, OPC_JALR,
            OPC_SYSTEM, OPC_MISC_MEM: fmt = FMT_I;
            OPC_STORE:                fmt = FMT_S;
            OPC_BRANCH:               fmt = FMT_B;
            OPC_LUI, OPC_AUIPC:       fmt = FMT_U;
            OPC_JAL:                  fmt = FMT_J;
            default:                  fmt = FMT_R;
        endcase
    end

    always_comb begin
        unique case (fmt)
            FMT_I:   imm = {{21{instr[31]}}, instr[30:20]};
            FMT_S:   imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
            FMT_B:   imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            FMT_U:   imm = {instr[31:12], 12'b0};
            FMT_J:   imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    // Source usage follows the format only
    assign use_rs1 = (fmt inside {FMT_R, FMT_I, FMT_S, FMT_B});
    assign use_rs2 = (fmt inside {FMT_R, FMT_S, FMT_B});

    always_comb begin
        decoded_o.op             = op;
        decoded_o.format         = fmt;
        decoded_o.rd             = instr[11:7];
        decoded_o.rs1            = instr[19:15];
        decoded_o.rs2            = instr[24:20];
        decoded_o.imm            = imm;
        decoded_o.use_rs1        = use_rs1;
        decoded_o.use_rs2        = use_rs2;
        decoded_o.is_load        = (opcode == OPC_LOAD);
        decoded_o.is_store       = (opcode == OPC_STORE);
        decoded_o.exc_illegal    = (instr[1:0] != 2'b11) || (op == INVALID);
        decoded_o.exc_misaligned = (fetch_i.pc[1:0] != 2'b00);   // No compressed fetch
    end

endmodule

`default_nettype wire

//--- design/issue_register.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_defs.svh"

module issue_register (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   enable_i,
    input  logic                   bubble_i,
    input  logic [`XLEN-1:0]       pc_i,
    input  decode_pkg::decoded_t   decoded_i,
    input  logic [`XLEN-1:0]       rs1_data_i,
    input  logic [`XLEN-1:0]       rs2_data_i,
    input  logic [`XLEN-1:0]       second_operand_i,
    input  logic [`XLEN-1:0]       jump_target_i,
    output decode_pkg::issue_pkt_t issue_o
);
    import decode_pkg::*;

    issue_pkt_t next_pkt;
    issue_pkt_t data_q;
    operation_e op_q;
    logic       exc_illegal_q;
    logic       exc_misaligned_q;
    logic       is_system;

    assign is_system = decoded_i.op inside {ECALL, EBREAK, MRET, SRET, WFI,
                                            CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI};

    ////////////////////////////////////////
    // Next packet
    ////////////////////////////////////////

    always_comb begin
        next_pkt.op             = bubble_i ? NOP : decoded_i.op;
        next_pkt.pc             = pc_i;
        next_pkt.rd             = decoded_i.rd;
        next_pkt.rs1            = decoded_i.rs1;
        next_pkt.rs1_data       = rs1_data_i;
        next_pkt.rs2_data       = rs2_data_i;
        next_pkt.second_operand = second_operand_i;
        next_pkt.jump_target    = jump_target_i;
        next_pkt.exc_illegal    = decoded_i.exc_illegal;
        next_pkt.exc_misaligned = decoded_i.exc_misaligned;
        // I immediate holds instr[31:20], the CSR number
        if (decoded_i.format == FMT_I && is_system)
            next_pkt.csr_address = decoded_i.imm[`CSR_ADDR_W-1:0];
        else
            next_pkt.csr_address = '0;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            op_q             <= NOP;
            exc_illegal_q    <= 1'b0;
            exc_misaligned_q <= 1'b0;
        end else if (enable_i) begin
            op_q             <= next_pkt.op;
            exc_illegal_q    <= next_pkt.exc_illegal;
            exc_misaligned_q <= next_pkt.exc_misaligned;
        end
    end

    always_ff @(posedge clk) begin
        if (enable_i)
            data_q <= next_pkt;
    end

    // Control fields come from the reset flops
    always_comb begin
        issue_o                = data_q;
        issue_o.op             = op_q;
        issue_o.exc_illegal    = exc_illegal_q;
        issue_o.exc_misaligned = exc_misaligned_q;
    end

endmodule

`default_nettype wire

//--- design/operand_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_defs.svh"

module operand_select (
    input  decode_pkg::decoded_t decoded_i,
    input  logic [`XLEN-1:0]     pc_i,
    input  logic [`XLEN-1:0]     rs1_rdata_i,
    input  logic [`XLEN-1:0]     rs2_rdata_i,
    input  decode_pkg::fwd_t     exec_fwd_i,
    input  decode_pkg::fwd_t     retire_fwd_i,
    output logic [`XLEN-1:0]     rs1_data_o,
    output logic [`XLEN-1:0]     rs2_data_o,
    output logic [`XLEN-1:0]     second_operand_o,
    output logic [`XLEN-1:0]     jump_target_o
);
    import decode_pkg::*;

    // Youngest writer wins, register file last
    function automatic logic [`XLEN-1:0] bypass(
        input logic [`REG_ADDR_W-1:0] rs,
        input logic [`XLEN-1:0]       rdata,
        input fwd_t                   exec_src,
        input fwd_t                   retire_src
    );
        logic [`XLEN-1:0] data;
        if (exec_src.we && exec_src.rd == rs)
            data = exec_src.data;
        else if (retire_src.we && retire_src.rd == rs)
            data = retire_src.data;
        else
            data = rdata;
        return data;
    endfunction

    assign rs1_data_o = bypass(decoded_i.rs1, rs1_rdata_i, exec_fwd_i, retire_fwd_i);
    assign rs2_data_o = bypass(decoded_i.rs2, rs2_rdata_i, exec_fwd_i, retire_fwd_i);

    always_comb begin
        unique case (decoded_i.format)
            FMT_I, FMT_S, FMT_U: second_operand_o = decoded_i.imm;
            default:             second_operand_o = rs2_data_o;
        endcase
    end

    // Target for JAL and branches, AUIPC result as well
    assign jump_target_o = pc_i + decoded_i.imm;

endmodule

`default_nettype wire

//--- sim/tb_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_defs.svh"

module tb_decode_stage;
    import decode_pkg::*;

    localparam integer CLK_PERIOD = 20;
    localparam integer N_RANDOM   = 24;
    // Cycles per test summed for the watchdog
    localparam integer RUN_CYCLES = 6 + 4 * N_RANDOM + 20 + 6 + 16 + 12 + 12;
    localparam integer TIMEOUT_NS = (2 * RUN_CYCLES + 100) * CLK_PERIOD;

    localparam logic [6:0] LOAD_OPC   = 7'h03;
    localparam logic [6:0] OPIMM_OPC  = 7'h13;
    localparam logic [6:0] STORE_OPC  = 7'h23;
    localparam logic [6:0] OP_OPC     = 7'h33;
    localparam logic [6:0] SYSTEM_OPC = 7'h73;
    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;   // addi x0, x0, 0

    logic clk;
    logic reset_n;
    logic enable_i;
    logic flush_i;
    fetch_pkt_t fetch_i;
    logic [`REG_ADDR_W-1:0] rs1_addr_o;
    logic [`REG_ADDR_W-1:0] rs2_addr_o;
    logic [`XLEN-1:0] rs1_rdata_i;
    logic [`XLEN-1:0] rs2_rdata_i;
    fwd_t exec_fwd_i;
    fwd_t retire_fwd_i;
    issue_pkt_t issue_o;
    logic hazard_o;
    logic killed_o;

    logic [`XLEN-1:0] rf_val [32];   // Register file model contents
    integer seed;
    integer errors;
    integer tests;
    integer failed_tests;
    integer errors_at_start;
    logic [31:0] cur_pc;
    logic next_flush;
    logic next_enable;
    fwd_t next_exec;
    fwd_t next_retire;

    // OP table rows that OP-IMM shares except SUB
    logic [2:0] alu_f3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    logic [6:0] alu_f7 [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h20,
                                7'h00, 7'h00};
    operation_e alu_op [10] = '{ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND};
    logic [2:0] br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    operation_e br_op [6] = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};

    decode_stage dut_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .enable_i     (enable_i),
        .flush_i      (flush_i),
        .fetch_i      (fetch_i),
        .rs1_addr_o   (rs1_addr_o),
        .rs2_addr_o   (rs2_addr_o),
        .rs1_rdata_i  (rs1_rdata_i),
        .rs2_rdata_i  (rs2_rdata_i),
        .exec_fwd_i   (exec_fwd_i),
        .retire_fwd_i (retire_fwd_i),
        .issue_o      (issue_o),
        .hazard_o     (hazard_o),
        .killed_o     (killed_o)
    );

    assign rs1_rdata_i = rf_val[rs1_addr_o];   // Combinational read
    assign rs2_rdata_i = rf_val[rs2_addr_o];

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // killed_o is flush_i one enabled cycle later
    assert property (@(posedge clk) disable iff (!reset_n)
                     $past(enable_i) |-> killed_o == $past(flush_i))
    else begin
        errors++;
        $display("** Error at %0t ns: killed_o does not follow flush_i", $time);
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("ERRORS FOUND");
        $finish;
    end

    ////////////////////////////////////////
    // Encoders
    ////////////////////////////////////////

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], STORE_OPC};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    ////////////////////////////////////////
    // Stimulus and check helpers
    ////////////////////////////////////////

    // Drives at the rising edge and returns at the falling edge where outputs are stable
    task automatic send_at(input logic [31:0] ins, input logic [31:0] pc);
        @(posedge clk);
        fetch_i.pc          <= pc;
        fetch_i.instruction <= ins;
        flush_i             <= next_flush;
        enable_i            <= next_enable;
        exec_fwd_i          <= next_exec;
        retire_fwd_i        <= next_retire;
        @(negedge clk);
    endtask

    task automatic send(input logic [31:0] ins);
        send_at(ins, cur_pc);
        cur_pc = cur_pc + 32'd4;
    endtask

    task automatic check(input logic ok, input string what);
        assert (ok) else begin
            errors++;
            $display("** Error at %0t ns: %s", $time, what);
        end
    endtask

    task automatic check_op(input operation_e exp);
        operation_e got;
        got = issue_o.op;
        check(got == exp, $sformatf("op %s, expected %s", got.name(), exp.name()));
    endtask

    task automatic begin_test();
        errors_at_start = errors;
        tests++;
    endtask

    task automatic end_test(input string name);
        if (errors == errors_at_start) begin
            $display("%-28s ok", name);
        end else begin
            failed_tests++;
            $display("%-28s failed", name);
        end
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic test_arith();
        integer i;
        integer k;
        logic [11:0] imm;
        logic [31:0] word;
        logic [31:0] pc;
        logic [4:0] rs2;
        begin_test();
        for (i = 0; i < 2 * N_RANDOM; i++) begin
            k = {$random(seed)} % 10;
            word = $random(seed);
            rs2 = word[24:20];
            pc = cur_pc;
            if (i % 2 == 0) begin   // OP
                send(enc_r(alu_f7[k], rs2, word[19:15], alu_f3[k], word[11:7], OP_OPC));
                send(NOP_INSTR);
                check_op(alu_op[k]);
                check(issue_o.second_operand == rf_val[rs2], "OP second operand not rs2");
            end else begin
                if (k == 1)
                    k = 0;
                imm = word[31:20];
                if (alu_f3[k] == 3'd1 || alu_f3[k] == 3'd5)
                    imm = {alu_f7[k], word[24:20]};
                send(enc_i(imm, word[19:15], alu_f3[k], word[11:7], OPIMM_OPC));
                send(NOP_INSTR);
                check_op(alu_op[k]);
                check(issue_o.second_operand == {{20{imm[11]}}, imm},
                      "OP-IMM second operand not the I immediate");
            end
            check(issue_o.pc == pc && issue_o.rd == word[11:7],
                  "pc or rd not carried into the issue packet");
        end
        end_test("arithmetic decode");
    endtask

    task automatic test_control();
        integer kind;
        integer k;
        logic [31:0] word;
        logic [31:0] pc;
        logic [31:0] exp_imm;
        operation_e exp_op;
        begin_test();
        for (kind = 0; kind < 8; kind++) begin
            word = $random(seed);
            cur_pc = $random(seed);
            cur_pc[1:0] = 2'b00;
            pc = cur_pc;
            k = {$random(seed)} % 6;
            case (kind % 4)
                0: begin
                    exp_imm = {{11{word[20]}}, word[20:1], 1'b0};
                    exp_op = JAL;
                    send(enc_j({word[20:1], 1'b0}, 5'd1));
                end
                1: begin
                    exp_imm = {{19{word[12]}}, word[12:1], 1'b0};
                    exp_op = br_op[k];
                    send(enc_b({word[12:1], 1'b0}, word[24:20], word[19:15], br_f3[k]));
                end
                2: begin
                    exp_imm = {word[31:12], 12'b0};
                    exp_op = LUI;
                    send({word[31:12], 5'd3, 7'h37});
                end
                default: begin
                    exp_imm = {word[31:12], 12'b0};
                    exp_op = AUIPC;
                    send({word[31:12], 5'd3, 7'h17});
                end
            endcase
            send(NOP_INSTR);
            check_op(exp_op);
            check(issue_o.jump_target == pc + exp_imm, "jump target not pc plus immediate");
        end
        send(enc_i(12'h300, 5'd2, 3'b001, 5'd1, SYSTEM_OPC));
        send(enc_i(12'h341, 5'd7, 3'b110, 5'd1, SYSTEM_OPC));
        check_op(CSRRW);
        check(issue_o.csr_address == 12'h300, "CSRRW address");
        send(NOP_INSTR);
        check_op(CSRRSI);
        check(issue_o.csr_address == 12'h341 && issue_o.rs1 == 5'd7, "CSRRSI address or uimm");
        end_test("control-flow targets");
    endtask

    task automatic test_forward();
        logic [31:0] add_x7;
        begin_test();
        add_x7 = enc_r(7'h00, 5'd7, 5'd7, 3'd0, 5'd3, OP_OPC);
        next_exec = '{we: 1'b1, rd: 5'd7, data: 32'hE0E0_0001};
        next_retire = '{we: 1'b1, rd: 5'd7, data: 32'hB0B0_0002};
        send(add_x7);
        next_exec.we = 1'b0;
        send(add_x7);
        check(issue_o.rs1_data == 32'hE0E0_0001 && issue_o.rs2_data == 32'hE0E0_0001,
              "execute source not taken first");
        next_retire.we = 1'b0;
        send(add_x7);
        check(issue_o.rs1_data == 32'hB0B0_0002 && issue_o.rs2_data == 32'hB0B0_0002,
              "retire source not taken");
        send(NOP_INSTR);
        check(issue_o.rs1_data == rf_val[7] && issue_o.rs2_data == rf_val[7],
              "register file data not taken");
        end_test("forwarding priority");
    endtask

    task automatic test_hazard();
        logic [31:0] add_x5;
        logic [31:0] load_x6;
        begin_test();
        add_x5 = enc_r(7'h00, 5'd2, 5'd5, 3'd0, 5'd6, OP_OPC);
        load_x6 = enc_i(12'h010, 5'd8, 3'b010, 5'd6, LOAD_OPC);
        send(enc_i(12'h000, 5'd1, 3'b010, 5'd5, LOAD_OPC));
        check(!hazard_o, "hazard on the load itself");
        send(add_x5);
        check(hazard_o, "no load-use hazard");
        send(add_x5);
        check(!hazard_o, "load-use hazard lasts more than one cycle");
        check_op(NOP);
        send(NOP_INSTR);
        check_op(ADD);
        send(enc_s(12'h004, 5'd2, 5'd1, 3'b010));
        send(load_x6);
        check(hazard_o, "no store-to-load hazard");
        send(load_x6);
        check(!hazard_o, "store-to-load hazard lasts more than one cycle");
        check_op(NOP);
        send(NOP_INSTR);
        check_op(LW);
        send(enc_i(12'h000, 5'd1, 3'b010, 5'd0, LOAD_OPC));
        send(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd6, OP_OPC));
        check(!hazard_o, "hazard on x0");
        send(NOP_INSTR);
        check_op(ADD);
        end_test("load-use hazard");
    endtask

    task automatic test_exceptions();
        logic [31:0] bad [3];
        integer i;
        begin_test();
        bad[0] = enc_r(7'h00, 5'd5, 5'd5, 3'd0, 5'd6, OP_OPC) & 32'hFFFF_FFFC;
        bad[1] = enc_r(7'h01, 5'd5, 5'd5, 3'd0, 5'd6, OP_OPC);   // MUL pattern
        bad[2] = enc_r(7'h00, 5'd5, 5'd5, 3'd0, 5'd6, OP_OPC);
        for (i = 0; i < 3; i++) begin
            send(enc_i(12'h000, 5'd1, 3'b010, 5'd5, LOAD_OPC));
            if (i == 2)
                send_at(bad[i], 32'h0000_0202);
            else
                send(bad[i]);
            check(!hazard_o, "hazard raised on a trapping instruction");
            send(NOP_INSTR);
            check(issue_o.exc_illegal == (i != 2), "illegal flag wrong");
            check(issue_o.exc_misaligned == (i == 2), "misaligned flag wrong");
        end
        end_test("exceptions");
    endtask

    task automatic test_flush_freeze();
        issue_pkt_t held;
        begin_test();
        send(enc_i(12'h000, 5'd1, 3'b010, 5'd5, LOAD_OPC));
        next_flush = 1'b1;
        send(enc_r(7'h00, 5'd2, 5'd5, 3'd0, 5'd6, OP_OPC));
        check(!hazard_o, "hazard raised during flush");
        next_flush = 1'b0;
        send(NOP_INSTR);
        check_op(NOP);
        check(killed_o, "killed_o low after flush");
        send(enc_i(12'h005, 5'd0, 3'b000, 5'd1, OPIMM_OPC));
        check(!killed_o, "killed_o stays high");
        next_enable = 1'b0;
        send(NOP_INSTR);
        held = issue_o;
        send(enc_r(7'h20, 5'd3, 5'd4, 3'd0, 5'd9, OP_OPC));
        check(issue_o == held, "issue_o changed while frozen");
        next_enable = 1'b1;
        send(enc_i(12'h123, 5'd4, 3'b100, 5'd9, OPIMM_OPC));
        check(issue_o == held, "issue_o changed on the second frozen edge");
        end_test("flush and freeze");
    endtask

    initial begin
        integer i;
        seed = 2501;
        errors = 0;
        tests = 0;
        failed_tests = 0;
        errors_at_start = 0;
        for (i = 0; i < 32; i++)
            rf_val[i] = $random(seed);
        cur_pc = 32'h0000_1000;
        next_flush = 1'b0;
        next_enable = 1'b1;
        next_exec = '0;
        next_retire = '0;
        reset_n = 1'b0;
        enable_i = 1'b1;
        flush_i = 1'b0;
        fetch_i.pc = cur_pc;
        fetch_i.instruction = NOP_INSTR;
        exec_fwd_i = '0;
        retire_fwd_i = '0;
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        begin_test();
        check_op(NOP);
        check(!hazard_o && !killed_o, "hazard_o or killed_o high after reset");
        check(!issue_o.exc_illegal && !issue_o.exc_misaligned, "exception flag after reset");
        end_test("reset values");
        test_arith();
        test_control();
        test_forward();
        test_hazard();
        test_exceptions();
        test_flush_freeze();
        $display("Tests: %0d run, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire
